// ==== plic_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// AXI-Lite bus definitions for the interrupt controller
// Slave FSM states, response codes and bus widths
//////////////////////////////////////////////////////////////////////

`default_nettype none

package plic_bus_pkg;

    // Bus widths
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ADDR_W = 32;

    // Read data returned for an unmapped address
    localparam logic [AXI_DATA_W-1:0] DECERR_DATA = 32'hffff_ffff;

    // Slave FSM states
    // One transaction at a time, reads and writes never overlap
    typedef enum logic [1:0] {
        SLAVE_IDLE,
        SEND_READ_DATA,
        RECEIVE_WRITE_DATA,
        SEND_WRITE_RESP
    } axi_slave_state_e;

    // Response codes
    // Only OKAY and DECERR are ever produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

// ==== plic_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt controller register map
//////////////////////////////////////////////////////////////////////

`default_nettype none

package plic_pkg;

    // Register offsets
    // Enable bits, one per source, low bits of the word
    localparam logic [31:0] REG_ENABLE = 32'h0000_0000;

    // Claim on read, complete on write of the claimed ID
    localparam logic [31:0] REG_CLAIM_COMPLETE = 32'h0000_0004;

    // Reserved ID
    // Source i is reported as ID i+1
    // so this value always means nothing is pending
    localparam int NO_IRQ_ID = 0;

endpackage

`default_nettype wire

// ==== plic_gateway.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt gateway
// Synchronizes each interrupt line and masks it by its enable bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_gateway #(
    parameter int NUM_IRQS = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_IRQS-1:0] irq_in,
    input  logic [NUM_IRQS-1:0] enabled,
    output logic [NUM_IRQS-1:0] pending
);

    // First synchronizer stage, may go metastable
    logic [NUM_IRQS-1:0] irq_meta;
    // Second stage, safe to use in the clock domain
    logic [NUM_IRQS-1:0] irq_sync;

    // Two flops per line
    // A level change shows up on irq_sync two edges later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_meta <= '0;
            irq_sync <= '0;
        end else begin
            irq_meta <= irq_in;
            irq_sync <= irq_meta;
        end
    end

    // Level-sensitive pending bits
    // Enable acts without delay
    always_comb begin
        for (int i = 0; i < NUM_IRQS; i++) begin
            pending[i] = irq_sync[i] & enabled[i];
        end
    end

endmodule

`default_nettype wire

// ==== plic_id_select.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt ID selector
// Returns the ID of the highest-numbered pending source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_id_select #(
    parameter int NUM_IRQS = 5
) (
    input  logic [NUM_IRQS-1:0]              pending,
    output logic [$clog2(NUM_IRQS+1)-1:0]    max_id
);

    import plic_pkg::*;

    // Wide enough for IDs 0 to NUM_IRQS
    localparam int ID_W = $clog2(NUM_IRQS + 1);

    // Priority scan
    // No priorities or thresholds, the highest ID simply wins
    // Ascending loop, so the last set bit found is the winner
    always_comb begin
        max_id = ID_W'(NO_IRQ_ID);
        for (int i = 0; i < NUM_IRQS; i++) begin
            if (pending[i]) begin
                // Source i maps to ID i+1
                max_id = ID_W'(i + 1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== plic_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt controller register block
// AXI-Lite slave with enable register, claim/complete and notification
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_regs #(
    parameter int NUM_IRQS = 5
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Write address channel
    input  logic [plic_bus_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,

    // Write data channel
    input  logic [plic_bus_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic                                  wvalid,
    output logic                                  wready,

    // Write response channel
    output plic_bus_pkg::axi_resp_e               bresp,
    output logic                                  bvalid,
    input  logic                                  bready,

    // Read address channel
    input  logic [plic_bus_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,

    // Read data channel
    output logic [plic_bus_pkg::AXI_DATA_W-1:0]   rdata,
    output plic_bus_pkg::axi_resp_e               rresp,
    output logic                                  rvalid,
    input  logic                                  rready,

    // Controller side
    input  logic [NUM_IRQS-1:0]                   pending,
    input  logic [$clog2(NUM_IRQS+1)-1:0]         max_id,
    output logic [NUM_IRQS-1:0]                   enabled,
    output logic                                  ext_irq
);

    import plic_bus_pkg::*;
    import plic_pkg::*;

    localparam int ID_W = $clog2(NUM_IRQS + 1);

    // Bus FSM
    axi_slave_state_e state;

    // Captured write address, used while waiting for write data
    logic [AXI_ADDR_W-1:0] aw_addr_q;

    // A claim is open, notification held off until completion
    logic            in_service;
    // ID handed out by the last nonzero claim
    logic [ID_W-1:0] serviced_id;

    // Handshakes
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;

    // Address decode
    logic            rd_is_claim;
    logic            wr_is_enable;
    logic            wr_is_claim;
    logic [AXI_DATA_W-1:0] rd_data_next;
    axi_resp_e       rd_resp_next;

    // Ready and valid come straight from the state
    // A read wins a tie with a write in idle
    assign arready = (state == SLAVE_IDLE);
    assign awready = (state == SLAVE_IDLE) && !arvalid;
    assign wready  = (state == RECEIVE_WRITE_DATA);
    assign rvalid  = (state == SEND_READ_DATA);
    assign bvalid  = (state == SEND_WRITE_RESP);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign r_hs  = rvalid && rready;
    assign b_hs  = bvalid && bready;

    assign rd_is_claim  = (araddr == REG_CLAIM_COMPLETE);
    assign wr_is_enable = (aw_addr_q == REG_ENABLE);
    assign wr_is_claim  = (aw_addr_q == REG_CLAIM_COMPLETE);

    // Read decode on the live address
    // Result is latched at the address handshake
    always_comb begin
        case (araddr)
            REG_ENABLE: begin
                rd_data_next = AXI_DATA_W'(enabled);
                rd_resp_next = RESP_OKAY;
            end
            REG_CLAIM_COMPLETE: begin
                rd_data_next = AXI_DATA_W'(max_id);
                rd_resp_next = RESP_OKAY;
            end
            default: begin
                rd_data_next = DECERR_DATA;
                rd_resp_next = RESP_DECERR;
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= SLAVE_IDLE;
            enabled     <= '0;
            in_service  <= 1'b0;
            serviced_id <= '0;
        end else begin
            case (state)
                SLAVE_IDLE: begin
                    if (ar_hs) begin
                        state <= SEND_READ_DATA;
                        // Claim takes effect together with the address
                        if (rd_is_claim) begin
                            if (max_id != ID_W'(NO_IRQ_ID)) begin
                                in_service  <= 1'b1;
                                serviced_id <= max_id;
                            end else begin
                                in_service <= 1'b0;
                            end
                        end
                    end else if (aw_hs) begin
                        state <= RECEIVE_WRITE_DATA;
                    end
                end
                RECEIVE_WRITE_DATA: begin
                    if (w_hs) begin
                        state <= SEND_WRITE_RESP;
                        if (wr_is_enable) begin
                            enabled <= wdata[NUM_IRQS-1:0];
                        end
                        // Completion only for the ID that was claimed
                        if (wr_is_claim && (wdata == AXI_DATA_W'(serviced_id))) begin
                            in_service <= 1'b0;
                        end
                    end
                end
                SEND_READ_DATA: begin
                    if (r_hs) begin
                        state <= SLAVE_IDLE;
                    end
                end
                SEND_WRITE_RESP: begin
                    if (b_hs) begin
                        state <= SLAVE_IDLE;
                    end
                end
                default: begin
                    state <= SLAVE_IDLE;
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (ar_hs) begin
            rdata <= rd_data_next;
            rresp <= rd_resp_next;
        end
        // Unmapped writes are dropped and flagged
        if (w_hs) begin
            bresp <= (wr_is_enable || wr_is_claim) ? RESP_OKAY : RESP_DECERR;
        end
    end

    // Target notification
    assign ext_irq = (|pending) && !in_service;

endmodule

`default_nettype wire

// ==== plic_top.sv ====
//////////////////////////////////////////////////////////////////////
// Platform-level interrupt controller
// Gateway, ID selector and AXI-Lite register block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_top #(
    parameter int NUM_IRQS = 5
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Asynchronous interrupt lines
    input  logic [NUM_IRQS-1:0]                   irq_in,

    // AXI-Lite slave port
    input  logic [plic_bus_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [plic_bus_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic                                  wvalid,
    output logic                                  wready,
    output plic_bus_pkg::axi_resp_e               bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [plic_bus_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [plic_bus_pkg::AXI_DATA_W-1:0]   rdata,
    output plic_bus_pkg::axi_resp_e               rresp,
    output logic                                  rvalid,
    input  logic                                  rready,

    // Notification to the core
    output logic                                  ext_irq
);

    localparam int ID_W = $clog2(NUM_IRQS + 1);

    logic [NUM_IRQS-1:0] enabled;
    logic [NUM_IRQS-1:0] pending;
    logic [ID_W-1:0]     max_id;

    // Sync and mask
    plic_gateway #(
        .NUM_IRQS (NUM_IRQS)
    ) u_gateway (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_in  (irq_in),
        .enabled (enabled),
        .pending (pending)
    );

    // Highest pending ID
    plic_id_select #(
        .NUM_IRQS (NUM_IRQS)
    ) u_id_select (
        .pending (pending),
        .max_id  (max_id)
    );

    plic_regs #(
        .NUM_IRQS (NUM_IRQS)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .pending (pending),
        .max_id  (max_id),
        .enabled (enabled),
        .ext_irq (ext_irq)
    );

endmodule

`default_nettype wire

// ==== plic_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// Bus protocol and notification checks for the register block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_assertions (
    input logic clk,
    input logic rst_n,
    input logic arvalid,
    input logic arready,
    input logic wvalid,
    input logic wready,
    input logic rvalid,
    input logic rready,
    input logic bvalid,
    input logic bready,
    input logic claim_taken,
    input logic in_service,
    input logic ext_irq
);

    // Read response held until taken
    property p_rvalid_hold;
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid;
    endproperty

    // Write response held until taken
    property p_bvalid_hold;
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid;
    endproperty

    // Read response opens only after an accepted read address
    property p_rvalid_after_ar;
        @(posedge clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(arvalid && arready);
    endproperty

    // Write response opens only after accepted write data
    property p_bvalid_after_w;
        @(posedge clk) disable iff (!rst_n)
        $rose(bvalid) |-> $past(wvalid && wready);
    endproperty

    // Nonzero claim opens service and masks the core notification
    property p_claim_masks_irq;
        @(posedge clk) disable iff (!rst_n)
        claim_taken |=> in_service && !ext_irq;
    endproperty

    a_rvalid_hold: assert property (p_rvalid_hold)
        else $error("rvalid dropped before rready");
    a_bvalid_hold: assert property (p_bvalid_hold)
        else $error("bvalid dropped before bready");
    a_rvalid_after_ar: assert property (p_rvalid_after_ar)
        else $error("rvalid rose without a read address handshake");
    a_bvalid_after_w: assert property (p_bvalid_after_w)
        else $error("bvalid rose without a write data handshake");
    a_claim_masks_irq: assert property (p_claim_masks_irq)
        else $error("claim did not open service and mask ext_irq");

endmodule

bind plic_regs plic_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .arvalid     (arvalid),
    .arready     (arready),
    .wvalid      (wvalid),
    .wready      (wready),
    .rvalid      (rvalid),
    .rready      (rready),
    .bvalid      (bvalid),
    .bready      (bready),
    .claim_taken (ar_hs && rd_is_claim && (max_id != '0)),
    .in_service  (in_service),
    .ext_irq     (ext_irq)
);

`default_nettype wire

// ==== plic_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the interrupt controller
// Random bus and interrupt stimulus checked against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module plic_tb;

    import plic_bus_pkg::*;
    import plic_pkg::*;

    localparam int NUM_IRQS = 5;
    // Bus transactions issued by all tests together
    localparam int NUM_TXN  = 84;
    localparam logic [31:0] EN_MASK = (32'h1 << NUM_IRQS) - 1;

    logic clk;
    logic rst_n;
    logic [NUM_IRQS-1:0] irq_in;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    axi_resp_e bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    axi_resp_e rresp;
    logic rvalid;
    logic rready;
    logic ext_irq;

    // Reference model state as it will be after the next rising edge
    logic [NUM_IRQS-1:0] meta_q;
    logic [NUM_IRQS-1:0] sync_q;
    logic [NUM_IRQS-1:0] enable_q;
    logic in_service_q;
    logic [31:0] serviced_q;
    logic [31:0] m_awaddr;

    // Expected responses with one entry per accepted address
    logic [31:0] exp_rdata_q[$];
    axi_resp_e exp_rresp_q[$];
    axi_resp_e exp_bresp_q[$];

    int err_count;
    int test_err_start;
    int pass_count;
    int fail_count;
    time ar_time;
    time aw_time;

    plic_top #(
        .NUM_IRQS (NUM_IRQS)
    ) u_dut (
        .clk(clk), .rst_n(rst_n), .irq_in(irq_in),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .ext_irq(ext_irq)
    );

    always #2 clk = ~clk;

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (exp !== act) begin
            $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
            err_count++;
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b at %0t", name, exp, act, $time);
            err_count++;
        end
    endtask

    // Single valid or ready bit of the bus
    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_count++;
        end
    endtask

    // Highest ID among the set lines
    // Source i is ID i+1
    function automatic logic [31:0] highest_id(input logic [NUM_IRQS-1:0] lines);
        highest_id = NO_IRQ_ID;
        for (int i = NUM_IRQS - 1; i >= 0; i--) begin
            if (lines[i] && highest_id == NO_IRQ_ID) begin
                highest_id = i + 1;
            end
        end
    endfunction

    // Model step at the falling edge
    // Inputs and handshakes seen here take effect at the next rising edge
    always @(negedge clk) begin : model_step
        logic [NUM_IRQS-1:0] m_pend;
        logic [31:0] m_id;
        m_pend = sync_q & enable_q;
        m_id = highest_id(m_pend);
        if (!rst_n) begin
            meta_q = '0;
            sync_q = '0;
            enable_q = '0;
            in_service_q = 1'b0;
            serviced_q = '0;
        end else begin
            check_irq("notify", (|m_pend) && !in_service_q, ext_irq);
            if (arvalid && arready) begin
                if (araddr == REG_ENABLE) begin
                    exp_rdata_q.push_back(32'(enable_q));
                    exp_rresp_q.push_back(RESP_OKAY);
                end else if (araddr == REG_CLAIM_COMPLETE) begin
                    exp_rdata_q.push_back(m_id);
                    exp_rresp_q.push_back(RESP_OKAY);
                    // Claim of nothing closes any open claim
                    in_service_q = (m_id != NO_IRQ_ID);
                    if (m_id != NO_IRQ_ID) begin
                        serviced_q = m_id;
                    end
                end else begin
                    exp_rdata_q.push_back(DECERR_DATA);
                    exp_rresp_q.push_back(RESP_DECERR);
                end
            end
            if (awvalid && awready) begin
                m_awaddr = awaddr;
            end
            if (wvalid && wready) begin
                if (m_awaddr == REG_ENABLE) begin
                    enable_q = wdata[NUM_IRQS-1:0];
                end
                if (m_awaddr == REG_CLAIM_COMPLETE && wdata == serviced_q) begin
                    in_service_q = 1'b0;
                end
                if (m_awaddr == REG_ENABLE || m_awaddr == REG_CLAIM_COMPLETE) begin
                    exp_bresp_q.push_back(RESP_OKAY);
                end else begin
                    exp_bresp_q.push_back(RESP_DECERR);
                end
            end
            // Two-flop synchronizer
            sync_q = meta_q;
            meta_q = irq_in;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Read with valid held until accepted
    // rready delayed 0 to 3 cycles
    task automatic axi_read(input string name, input logic [31:0] addr,
                            output logic [31:0] data, output axi_resp_e resp);
        int unsigned hold;
        hold = $urandom % 4;
        araddr = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        ar_time = $time;
        next_cycle();
        arvalid = 1'b0;
        repeat (hold) next_cycle();
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
        if (exp_rdata_q.size() == 0) begin
            $display("%s: read response arrived without an accepted address", name);
            err_count++;
        end else begin
            check_data(name, exp_rdata_q.pop_front(), data);
            check_resp(name, exp_rresp_q.pop_front(), resp);
        end
    endtask

    // Write with address first and data second
    // bready delayed 0 to 3 cycles
    task automatic axi_write(input string name, input logic [31:0] addr,
                             input logic [31:0] data, output axi_resp_e resp);
        int unsigned hold;
        hold = $urandom % 4;
        awaddr = addr;
        awvalid = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        aw_time = $time;
        next_cycle();
        awvalid = 1'b0;
        wdata = data;
        wvalid = 1'b1;
        @(negedge clk);
        while (!wready) @(negedge clk);
        next_cycle();
        wvalid = 1'b0;
        repeat (hold) next_cycle();
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        next_cycle();
        bready = 1'b0;
        if (exp_bresp_q.size() == 0) begin
            $display("%s: write response arrived without accepted data", name);
            err_count++;
        end else begin
            check_resp(name, exp_bresp_q.pop_front(), resp);
        end
    endtask

    // Explicit notification check at a stable point
    // Returns at drive time
    task automatic sample_irq(input string name, input logic exp);
        @(negedge clk);
        check_irq(name, exp, ext_irq);
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_start) begin
            $display("test %s: PASS", name);
            pass_count++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, err_count - test_err_start);
            fail_count++;
        end
        test_err_start = err_count;
    endtask

    // Watchdog sized from the transaction count
    initial begin
        repeat (NUM_TXN * 40 + 200) @(posedge clk);
        $display("Timeout: a bus transaction never completed");
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] rd_tie;
        logic [31:0] val;
        logic [31:0] id;
        logic [31:0] en_shadow;
        axi_resp_e resp;
        axi_resp_e resp_tie;
        void'($urandom(32'h0cfe05ae));
        clk = 1'b0;
        rst_n = 1'b0;
        irq_in = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        err_count = 0;
        test_err_start = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        // Handshake outputs right after reset
        @(negedge clk);
        check_flag("reset_arready", 1'b1, arready);
        check_flag("reset_awready", 1'b1, awready);
        check_flag("reset_wready", 1'b0, wready);
        check_flag("reset_rvalid", 1'b0, rvalid);
        check_flag("reset_bvalid", 1'b0, bvalid);
        next_cycle();
        finish_test("reset_values");

        // Enable register read back
        for (int n = 0; n < 8; n++) begin
            val = $urandom;
            axi_write("enable_write", REG_ENABLE, val, resp);
            check_resp("enable_write_resp", RESP_OKAY, resp);
            axi_read("enable_read", REG_ENABLE, rd, resp);
            check_data("enable_readback", val & EN_MASK, rd);
            check_resp("enable_read_resp", RESP_OKAY, resp);
            en_shadow = val & EN_MASK;
        end
        finish_test("enable_register");

        // Notification follows lines and enables every cycle
        for (int n = 0; n < 4; n++) begin
            axi_write("notify_enable", REG_ENABLE, $urandom, resp);
            repeat (10) begin
                irq_in = $urandom;
                next_cycle();
            end
        end
        finish_test("notification");

        // Claim returns the highest pending ID and masks ext_irq
        axi_write("claim_enable", REG_ENABLE, EN_MASK, resp);
        en_shadow = EN_MASK;
        for (int n = 0; n < 6; n++) begin
            irq_in = (n == 0) ? '0 : NUM_IRQS'(($urandom % EN_MASK) + 1);
            repeat (3) next_cycle();
            axi_read("claim_read", REG_CLAIM_COMPLETE, id, resp);
            check_data("claim_id", highest_id(irq_in), id);
            if (id != NO_IRQ_ID) begin
                sample_irq("claim_mask", 1'b0);
                axi_write("claim_release", REG_CLAIM_COMPLETE, id, resp);
            end
        end
        finish_test("claim");

        // Complete only with the claimed ID
        for (int n = 0; n < 6; n++) begin
            irq_in = NUM_IRQS'(($urandom % EN_MASK) + 1);
            repeat (3) next_cycle();
            axi_read("complete_claim", REG_CLAIM_COMPLETE, id, resp);
            axi_write("complete_wrong", REG_CLAIM_COMPLETE, (id % NUM_IRQS) + 1, resp);
            sample_irq("complete_wrong_mask", 1'b0);
            axi_write("complete_right", REG_CLAIM_COMPLETE, id, resp);
            sample_irq("complete_reenable", 1'b1);
        end
        finish_test("complete");

        // Unmapped addresses answer DECERR and leave the enables alone
        for (int n = 0; n < 6; n++) begin
            val = (($urandom % 62) + 2) * 4;
            axi_read("unmapped_read", val, rd, resp);
            check_data("unmapped_rdata", DECERR_DATA, rd);
            check_resp("unmapped_rresp", RESP_DECERR, resp);
            axi_write("unmapped_write", val, $urandom, resp);
            check_resp("unmapped_bresp", RESP_DECERR, resp);
            axi_read("unmapped_keep", REG_ENABLE, rd, resp);
            check_data("unmapped_enable", en_shadow, rd);
        end
        finish_test("unmapped");

        // Simultaneous read and write where the read must go first
        for (int n = 0; n < 8; n++) begin
            val = $urandom;
            irq_in = $urandom;
            fork
                axi_read("tie_read", REG_ENABLE, rd_tie, resp);
                axi_write("tie_write", REG_ENABLE, val, resp_tie);
            join
            check_data("tie_read_old", en_shadow, rd_tie);
            check_resp("tie_write_resp", RESP_OKAY, resp_tie);
            if (ar_time >= aw_time) begin
                $display("tie: write address was accepted before the read address");
                err_count++;
            end
            en_shadow = val & EN_MASK;
        end
        finish_test("ties");

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
plic_bus_pkg.sv
plic_pkg.sv
plic_gateway.sv
plic_id_select.sv
plic_regs.sv
plic_top.sv
plic_assertions.sv
plic_tb.sv

// ==== Bender.yml ====
package:
  name: plic

sources:
  - plic_bus_pkg.sv
  - plic_pkg.sv
  - plic_gateway.sv
  - plic_id_select.sv
  - plic_regs.sv
  - plic_top.sv
  - target: test
    files:
      - plic_assertions.sv
      - plic_tb.sv
